// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_dma_path_controller
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: cmd_dispatch.sv
/*
 * command dispatcher
 * pops a message header with its source tag and issues a dram
 * read command, or a write command followed by its data beats
 */
`default_nettype none

module cmd_dispatch (
	input  wire                         fpu_clk,
	input  wire                         reset,
	input  wire fpu_msg_pkg::msg_beat_t beat_data,
	input  wire                         beat_empty,
	output logic                        beat_pop,
	input  wire fpu_msg_pkg::port_id_t  tag,
	input  wire                         tag_empty,
	output logic                        tag_pop,
	output dram_cmd_pkg::dram_cmd_t     rd_cmd,
	output logic                        rd_cmd_valid,
	input  wire                         rd_cmd_ready,
	output dram_cmd_pkg::dram_cmd_t     wr_cmd,
	output fpu_msg_pkg::beat_t          wr_data,
	output logic                        wr_valid,
	input  wire                         wr_ready
);
	import fpu_msg_pkg::*;
	import dram_cmd_pkg::*;

	typedef enum logic [1:0] {st_idle, st_read_cmd, st_write_data, st_discard} disp_state_t;

	disp_state_t state;
	dram_cmd_t   cmd_q;
	dram_cmd_t   hdr_cmd;
	msg_form_t   hdr_form;
	logic        start;

	// a tag means the whole message is already queued
	assign start = (state == st_idle) && !beat_empty && !tag_empty;

	//////////////////////////////////////////////////////////////////////
	// header decode
	always_comb begin
		hdr_cmd.length     = beat_data.data[len_lsb +: $bits(msg_len_t)];
		hdr_cmd.dram_addr  = beat_data.data[dram_lsb +: $bits(dram_addr_t)];
		hdr_cmd.dpram_addr = beat_data.data[dpram_lsb +: $bits(dpram_addr_t)];
		hdr_cmd.dpram_addr[src_field_lsb +: $bits(port_id_t)] = tag;
		hdr_cmd.dpram_addr[src_field_lsb - 1 -: 2] = 2'b00;   // bits 13:12 cleared
	end

	assign hdr_form = beat_data.data[form_lsb +: $bits(msg_form_t)];

	assign rd_cmd       = cmd_q;
	assign wr_cmd       = cmd_q;
	assign rd_cmd_valid = (state == st_read_cmd);
	assign wr_valid     = (state == st_write_data) && !beat_empty;
	assign wr_data      = beat_data.data;
	assign tag_pop      = start;
	assign beat_pop     = start || (wr_valid && wr_ready);

	always_ff @(posedge fpu_clk) begin
		if (start) begin
			cmd_q <= hdr_cmd;
		end
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (start) begin
						if (hdr_form == form_read) begin
							state <= st_read_cmd;
						end else if (hdr_form == form_write && !beat_data.last) begin
							state <= st_write_data;
						end else begin
							state <= st_discard;   // unknown form or empty write
						end
					end
				end
				st_read_cmd: begin
					if (rd_cmd_ready) begin
						state <= st_idle;
					end
				end
				st_write_data: begin
					if (wr_valid && wr_ready && beat_data.last) begin
						state <= st_idle;
					end
				end
				st_discard: state <= st_idle;   // single header beat, already popped
				default:    state <= st_idle;
			endcase
		end
	end

	assert property (@(posedge fpu_clk) disable iff (reset) !(rd_cmd_valid && wr_valid))
		else $error("cmd_dispatch read and write valid together");
	assert property (@(posedge fpu_clk) disable iff (reset)
		wr_valid && !wr_ready |=> wr_valid && $stable(wr_data) && $stable(wr_cmd))
		else $error("cmd_dispatch write beat changed under back-pressure");

endmodule

`default_nettype wire

// File: dma_path_controller.sv
/*
 * dma path controller top level
 * four fpu ports share one dram command path through a
 * token arbiter, a beat fifo, a tag fifo and a dispatcher
 */
`default_nettype none

module dma_path_controller (
	input  wire                        fpu_clk,
	input  wire                        reset,
	input  wire fpu_msg_pkg::fpu_req_t fpu_in  [fpu_msg_pkg::num_ports],
	output fpu_msg_pkg::fpu_rsp_t      fpu_out [fpu_msg_pkg::num_ports],
	output dram_cmd_pkg::dram_cmd_t    rd_cmd,
	output logic                       rd_cmd_valid,
	input  wire                        rd_cmd_ready,
	output dram_cmd_pkg::dram_cmd_t    wr_cmd,
	output fpu_msg_pkg::beat_t         wr_data,
	output logic                       wr_valid,
	input  wire                        wr_ready
);
	import fpu_msg_pkg::*;

	logic [num_ports-1:0] req;
	logic [num_ports-1:0] grant;
	port_id_t             grant_id;
	logic                 done;
	logic                 tag_push;
	logic                 beat_push;
	msg_beat_t            beat_in;
	logic                 beat_full;
	msg_beat_t            beat_out;
	logic                 beat_empty;
	logic                 beat_pop;
	port_id_t             tag_out;
	logic                 tag_full;
	logic                 tag_empty;
	logic                 tag_pop;
	logic                 cap_full;

	for (genvar i = 0; i < num_ports; i++) begin : g_req
		assign req[i] = fpu_in[i].req;
	end

	assign cap_full = beat_full | tag_full;   // intake stalls on either fifo

	token_arbiter u_arbiter (
		.fpu_clk(fpu_clk), .reset(reset), .req(req), .done(done),
		.grant(grant), .grant_id(grant_id), .tag_push(tag_push)
	);

	msg_capture u_capture (
		.fpu_clk(fpu_clk), .reset(reset), .grant(grant),
		.fpu_in(fpu_in), .fpu_out(fpu_out),
		.beat_push(beat_push), .beat_data(beat_in), .beat_full(cap_full), .done(done)
	);

	msg_fifo #(.width($bits(msg_beat_t)), .depth_log2(8)) beat_fifo (
		.fpu_clk(fpu_clk), .reset(reset),
		.push(beat_push), .push_data(beat_in), .full(beat_full),
		.pop(beat_pop), .pop_data(beat_out), .empty(beat_empty)
	);

	msg_fifo #(.width($bits(port_id_t)), .depth_log2(4)) tag_fifo (
		.fpu_clk(fpu_clk), .reset(reset),
		.push(tag_push), .push_data(grant_id), .full(tag_full),
		.pop(tag_pop), .pop_data(tag_out), .empty(tag_empty)
	);

	cmd_dispatch u_dispatch (
		.fpu_clk(fpu_clk), .reset(reset),
		.beat_data(beat_out), .beat_empty(beat_empty), .beat_pop(beat_pop),
		.tag(tag_out), .tag_empty(tag_empty), .tag_pop(tag_pop),
		.rd_cmd(rd_cmd), .rd_cmd_valid(rd_cmd_valid), .rd_cmd_ready(rd_cmd_ready),
		.wr_cmd(wr_cmd), .wr_data(wr_data), .wr_valid(wr_valid), .wr_ready(wr_ready)
	);

endmodule

`default_nettype wire

// File: dram_cmd_pkg.sv
/*
 * dram command definitions
 * command bundle and address widths toward the dma block
 */
`default_nettype none

package dram_cmd_pkg;

	typedef logic [39:0] dram_addr_t;
	typedef logic [15:0] dpram_addr_t;

	// source port sits in dpram address bits 15:14
	localparam int src_field_lsb = 14;

	typedef struct packed {
		fpu_msg_pkg::msg_len_t length;
		dram_addr_t            dram_addr;
		dpram_addr_t           dpram_addr;
	} dram_cmd_t;

endpackage

`default_nettype wire

// File: flist.f
fpu_msg_pkg.sv
dram_cmd_pkg.sv
msg_fifo.sv
token_arbiter.sv
msg_capture.sv
cmd_dispatch.sv
dma_path_controller.sv
tb_dma_path_controller.sv

// File: fpu_msg_pkg.sv
/*
 * fpu side message format
 * header field positions, form codes and the per-port
 * request and response bundles of the four fpu ports
 */
`default_nettype none

package fpu_msg_pkg;

	localparam int num_ports = 4;

	typedef logic [1:0]   port_id_t;
	typedef logic [127:0] beat_t;
	typedef logic [15:0]  msg_len_t;   // counts the header beat
	typedef logic [7:0]   msg_form_t;

	localparam msg_form_t form_read  = 8'h01;
	localparam msg_form_t form_write = 8'h03;

	// header beat layout
	localparam int form_lsb  = 72;
	localparam int len_lsb   = 56;
	localparam int dram_lsb  = 16;
	localparam int dpram_lsb = 0;

	typedef struct packed {
		logic  last;   // final beat of a message
		beat_t data;
	} msg_beat_t;

	typedef struct packed {
		logic  req;
		logic  write_valid;
		beat_t write_data;
	} fpu_req_t;

	typedef struct packed {
		logic resp;
		logic write_ready;
	} fpu_rsp_t;

endpackage

`default_nettype wire

// File: msg_capture.sv
/*
 * message intake for the port holding the token
 * raises resp until the header is taken, then collects the
 * message beats into the beat fifo and marks the last one
 */
`default_nettype none

module msg_capture (
	input  wire                               fpu_clk,
	input  wire                               reset,
	input  wire  [fpu_msg_pkg::num_ports-1:0] grant,
	input  wire fpu_msg_pkg::fpu_req_t        fpu_in  [fpu_msg_pkg::num_ports],
	output fpu_msg_pkg::fpu_rsp_t             fpu_out [fpu_msg_pkg::num_ports],
	output logic                              beat_push,
	output fpu_msg_pkg::msg_beat_t            beat_data,
	input  wire                               beat_full,
	output logic                              done
);
	import fpu_msg_pkg::*;

	typedef enum logic [1:0] {st_wait_header, st_body, st_finish} cap_state_t;

	cap_state_t state;
	logic       resp;       // one cycle behind grant
	msg_len_t   len_q;
	msg_len_t   beat_cnt;
	fpu_req_t   sel;
	logic       ready;
	logic       accept;
	msg_form_t  hdr_form;
	msg_len_t   hdr_len;
	logic       hdr_last;

	// granted port's inputs
	always_comb begin
		sel = '0;
		for (int i = 0; i < num_ports; i++) begin
			if (grant[i]) begin
				sel = fpu_in[i];
			end
		end
	end

	assign hdr_form = sel.write_data[form_lsb +: $bits(msg_form_t)];
	assign hdr_len  = sel.write_data[len_lsb +: $bits(msg_len_t)];
	// only a write longer than its header has a body
	assign hdr_last = (hdr_form != form_write) || (hdr_len <= msg_len_t'(1));

	assign ready  = ((state == st_wait_header) ? resp : (state == st_body)) && !beat_full;
	assign accept = sel.write_valid && ready;
	assign done   = (state == st_finish);

	assign beat_push      = accept;
	assign beat_data.data = sel.write_data;
	assign beat_data.last = (state == st_wait_header) ? hdr_last : (beat_cnt + 1'b1 >= len_q);

	//////////////////////////////////////////////////////////////////////
	// intake fsm
	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state    <= st_wait_header;
			resp     <= 1'b0;
			len_q    <= '0;
			beat_cnt <= '0;
		end else begin
			case (state)
				st_wait_header: begin
					if (accept) begin
						resp     <= 1'b0;
						len_q    <= hdr_len;
						beat_cnt <= msg_len_t'(1);
						state    <= hdr_last ? st_finish : st_body;
					end else if (|grant) begin
						resp <= 1'b1;
					end
				end
				st_body: begin
					if (accept) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (beat_data.last) begin
							state <= st_finish;
						end
					end
				end
				st_finish: state <= st_wait_header;   // done pulse
				default:   state <= st_wait_header;
			endcase
		end
	end

	// token holder only sees resp and write_ready
	always_comb begin
		for (int i = 0; i < num_ports; i++) begin
			fpu_out[i].resp        = grant[i] & resp;
			fpu_out[i].write_ready = grant[i] & ready;
		end
	end

endmodule

`default_nettype wire

// File: msg_fifo.sv
/*
 * synchronous first-word-fall-through fifo
 * head entry is always shown at pop_data while not empty
 */
`default_nettype none

module msg_fifo #(
	parameter int width      = 129,
	parameter int depth_log2 = 8
) (
	input  wire              fpu_clk,
	input  wire              reset,
	input  wire              push,
	input  wire [width-1:0]  push_data,
	output logic             full,
	input  wire              pop,
	output logic [width-1:0] pop_data,
	output logic             empty
);

	logic [width-1:0]      mem [0:(1 << depth_log2)-1];
	logic [depth_log2-1:0] wr_ptr;
	logic [depth_log2-1:0] rd_ptr;
	logic [depth_log2:0]   count;   // one extra bit for the full case

	assign full     = count[depth_log2];
	assign empty    = (count == '0);
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge fpu_clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assert property (@(posedge fpu_clk) disable iff (reset) push |-> !full)
		else $error("msg_fifo push while full");
	assert property (@(posedge fpu_clk) disable iff (reset) pop |-> !empty)
		else $error("msg_fifo pop while empty");

endmodule

`default_nettype wire

// File: tb_dma_path_controller.sv
/*
 * testbench for the dma path controller
 * four forked fpu drivers send a table of messages, a monitor
 * throttles the dma side and checks every command in order
 */
`default_nettype none

module tb_dma_path_controller;
	timeunit 1ns;
	timeprecision 1ps;
	import fpu_msg_pkg::*;
	import dram_cmd_pkg::*;

	localparam int num_msgs      = 12;
	localparam int max_len       = 8;
	localparam int ready_timeout = 1000;
	localparam int drain_timeout = 2000;

	typedef struct packed {
		port_id_t    port;
		msg_form_t   form;
		msg_len_t    len;
		dram_addr_t  dram;
		dpram_addr_t dpram;
	} msg_t;

	typedef struct packed {
		logic      is_write;
		dram_cmd_t cmd;
		beat_t     data;   // zero for reads
	} exp_evt_t;

	logic        fpu_clk;
	logic        reset;
	fpu_req_t    fpu_in  [num_ports];
	fpu_rsp_t    fpu_out [num_ports];
	dram_cmd_t   rd_cmd;
	logic        rd_cmd_valid;
	logic        rd_cmd_ready;
	dram_cmd_t   wr_cmd;
	beat_t       wr_data;
	logic        wr_valid;
	logic        wr_ready;

	msg_t        msg_tab [num_msgs];
	beat_t       payload [num_msgs][max_len];
	exp_evt_t    exp_q [$];
	logic [31:0] lfsr;
	int          errors = 0;

	dma_path_controller uut (
		.fpu_clk(fpu_clk), .reset(reset), .fpu_in(fpu_in), .fpu_out(fpu_out),
		.rd_cmd(rd_cmd), .rd_cmd_valid(rd_cmd_valid), .rd_cmd_ready(rd_cmd_ready),
		.wr_cmd(wr_cmd), .wr_data(wr_data), .wr_valid(wr_valid), .wr_ready(wr_ready)
	);

	initial begin
		fpu_clk = 1'b0;
		forever #2 fpu_clk = ~fpu_clk;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic fb;
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic beat_t make_header(input msg_t m);
		beat_t h;
		h        = '0;
		h[79:72] = m.form;
		h[71:56] = m.len;   // counts the header beat
		h[55:16] = m.dram;
		h[15:0]  = m.dpram;
		return h;
	endfunction

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic abort_run(input string why);
		$display("timeout: %s", why);
		$display("checks done, errors: %0d", errors);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	//////////////////////////////////////////////////////////////////////
	// expected commands straight from the table rules
	task automatic build_expected();
		exp_evt_t e;
		for (int k = 0; k < num_msgs; k++) begin
			e.is_write = (msg_tab[k].form == form_write);
			e.cmd      = '{msg_tab[k].len, msg_tab[k].dram,
				{msg_tab[k].port, 2'b00, msg_tab[k].dpram[11:0]}};
			e.data     = '0;
			if (msg_tab[k].form == form_read) begin
				exp_q.push_back(e);
			end else if (e.is_write) begin
				for (int b = 1; b < int'(msg_tab[k].len); b++) begin
					e.data = payload[k][b-1];
					exp_q.push_back(e);
				end
			end
		end
	endtask

	task automatic wait_ready(input int p);
		int cycles;
		cycles = 0;
		while (!fpu_out[p].write_ready && cycles < ready_timeout) begin
			@(negedge fpu_clk);
			cycles++;
		end
		if (!fpu_out[p].write_ready) abort_run($sformatf("port %0d never saw write_ready", p));
	endtask

	task automatic drive_port(input int p);
		int n_beats;
		for (int k = 0; k < num_msgs; k++) begin
			if (msg_tab[k].port == port_id_t'(p)) begin
				n_beats = (msg_tab[k].form == form_write && msg_tab[k].len > 1) ?
					int'(msg_tab[k].len) : 1;
				@(negedge fpu_clk);
				fpu_in[p].req         = 1'b1;
				fpu_in[p].write_valid = 1'b1;
				for (int b = 0; b < n_beats; b++) begin
					if (b == 0) fpu_in[p].write_data = make_header(msg_tab[k]);
					else fpu_in[p].write_data = payload[k][b-1];
					wait_ready(p);
					if (b == 0) check_value("resp", 128'(fpu_out[p].resp), 128'(1'b1));
					@(negedge fpu_clk);   // beat taken on the edge in between
				end
				fpu_in[p] = '0;
			end
		end
	endtask

	task automatic check_command(input logic is_write, input dram_cmd_t cmd, input beat_t data);
		exp_evt_t e;
		if (exp_q.size() == 0) begin
			errors++;
			$display("%s command seen with nothing expected", is_write ? "write" : "read");
		end else begin
			e = exp_q.pop_front();
			if (e.is_write != is_write) begin
				errors++;
				$display("got a %s command where the other kind was due",
					is_write ? "write" : "read");
			end else begin
				check_value(is_write ? "wr_cmd" : "rd_cmd", 128'(cmd), 128'(e.cmd));
				if (is_write) check_value("wr_data", data, e.data);
			end
		end
	endtask

	// random back-pressure, outputs stay put until the next rising edge
	always @(negedge fpu_clk) begin
		if (!reset) begin
			rd_cmd_ready = lfsr_bit() | lfsr_bit();
			wr_ready     = lfsr_bit() | lfsr_bit();
		end
		if (rd_cmd_valid && rd_cmd_ready) check_command(1'b0, rd_cmd, '0);
		if (wr_valid && wr_ready) check_command(1'b1, wr_cmd, wr_data);
	end

	//////////////////////////////////////////////////////////////////////
	initial begin : main
		int cycles;
		reset        = 1'b1;
		rd_cmd_ready = 1'b0;
		wr_ready     = 1'b0;
		lfsr         = 32'ha3110669;
		for (int i = 0; i < num_ports; i++) fpu_in[i] = '0;
		// port, form, length, dram address, dpram address
		msg_tab[0]  = '{2'd0, form_read,  16'd1, 40'h12_3456_7800, 16'hf001};
		msg_tab[1]  = '{2'd1, form_write, 16'd4, 40'h00_0000_1000, 16'h3102};
		msg_tab[2]  = '{2'd2, 8'h07,      16'd3, 40'h55_aaaa_0000, 16'h0203};
		msg_tab[3]  = '{2'd3, form_read,  16'd8, 40'hff_0000_0040, 16'hc304};
		msg_tab[4]  = '{2'd0, form_write, 16'd2, 40'h01_2000_0080, 16'h7fff};
		msg_tab[5]  = '{2'd1, form_read,  16'd1, 40'h80_0000_0000, 16'h0000};
		msg_tab[6]  = '{2'd2, form_write, 16'd5, 40'h3c_4d5e_6f00, 16'hb0a0};
		msg_tab[7]  = '{2'd3, form_write, 16'd1, 40'h00_0000_0200, 16'h1111};
		msg_tab[8]  = '{2'd0, 8'h00,      16'd1, 40'h00_0000_0300, 16'h2222};
		msg_tab[9]  = '{2'd1, form_write, 16'd3, 40'h0a_0b0c_0d00, 16'he5d6};
		msg_tab[10] = '{2'd2, form_read,  16'd2, 40'h7e_0000_1230, 16'h4c4c};
		msg_tab[11] = '{2'd3, form_write, 16'd3, 40'h11_2233_4450, 16'h9abc};
		for (int k = 0; k < num_msgs; k++)
			for (int b = 0; b < max_len; b++)
				for (int i = 0; i < $bits(beat_t); i++)
					payload[k][b][i] = lfsr_bit();
		build_expected();

		repeat (4) @(negedge fpu_clk);
		reset = 1'b0;
		repeat (2) @(negedge fpu_clk);
		for (int i = 0; i < num_ports; i++) begin
			check_value("resp", 128'(fpu_out[i].resp), '0);
			check_value("write_ready", 128'(fpu_out[i].write_ready), '0);
		end
		check_value("rd_cmd_valid", 128'(rd_cmd_valid), '0);
		check_value("wr_valid", 128'(wr_valid), '0);

		fork
			drive_port(0);
			drive_port(1);
			drive_port(2);
			drive_port(3);
		join

		cycles = 0;
		while (exp_q.size() != 0 && cycles < drain_timeout) begin
			@(negedge fpu_clk);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			abort_run($sformatf("%0d commands never came out", exp_q.size()));
		end else begin
			repeat (50) @(negedge fpu_clk);   // catch stray late commands
			$display("checks done, errors: %0d", errors);
			if (errors == 0)
				$display("SIMULATION PASSED");
			else
				$display("SIMULATION FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: token_arbiter.sv
/*
 * round-robin token arbiter for the four fpu ports
 * holds the token until the message is done, then queues
 * the served port number as a source tag
 */
`default_nettype none

module token_arbiter (
	input  wire                               fpu_clk,
	input  wire                               reset,
	input  wire  [fpu_msg_pkg::num_ports-1:0] req,
	input  wire                               done,
	output logic [fpu_msg_pkg::num_ports-1:0] grant,
	output fpu_msg_pkg::port_id_t             grant_id,
	output logic                              tag_push
);
	import fpu_msg_pkg::*;

	typedef enum logic {st_idle, st_busy} arb_state_t;

	arb_state_t state;
	port_id_t   last_served;
	port_id_t   next_id;
	logic       next_found;

	// search starts at the port after the one just served
	always_comb begin
		next_id    = last_served;
		next_found = 1'b0;
		for (int i = 1; i <= num_ports; i++) begin
			if (!next_found && req[last_served + port_id_t'(i)]) begin
				next_id    = last_served + port_id_t'(i);
				next_found = 1'b1;
			end
		end
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state       <= st_idle;
			grant       <= '0;
			grant_id    <= '0;
			last_served <= port_id_t'(num_ports - 1);   // first round opens at port a
		end else begin
			case (state)
				st_idle: begin
					if (next_found) begin
						grant    <= {{(num_ports-1){1'b0}}, 1'b1} << next_id;
						grant_id <= next_id;
						state    <= st_busy;
					end
				end
				st_busy: begin
					if (done) begin
						grant       <= '0;
						last_served <= grant_id;
						state       <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign tag_push = (state == st_busy) && done;   // tag follows the finished message

	assert property (@(posedge fpu_clk) disable iff (reset) $onehot0(grant))
		else $error("token_arbiter grant not one-hot");

endmodule

`default_nettype wire
